// File: Bender.yml
package:
  name: cpu_system

sources:
  - cpu_pkg.sv
  - mem_bus_if.sv
  - prog_loader.sv
  - cpu_core.sv
  - mem_ram.sv
  - mem_map.sv
  - cpu_system.sv
  - target: test
    files:
      - tb_checker.sv
      - tb_cpu_system.sv

// File: cpu_core.sv
// -------------------------------------------------------------------------
// cpu core
// fetch, decode, immediate load and execute cycles with four registers
// register transfer, load immediate, load and store over the memory bus
// -------------------------------------------------------------------------
`default_nettype none

module cpu_core #(
	parameter int ADDR_BITS = 8,
	parameter int WORD_BITS = 8
) (
	input wire in_clk,
	input wire in_rst,
	input wire core_hold,            // held in reset while loading
	mem_bus_if.master bus,
	output cpu_pkg::word_t out_instr // debug view of instr
);
	import cpu_pkg::*;

	localparam int NUM_REGS = WORD_BITS / 2;
	localparam int REG_BITS = $clog2(NUM_REGS);

	// widths are fixed by the package types
	if (ADDR_BITS != $bits(addr_t)) begin : g_addr_check
		$error("ADDR_BITS does not match addr_t");
	end
	if (WORD_BITS != $bits(word_t)) begin : g_word_check
		$error("WORD_BITS does not match word_t");
	end

	// -------------------------------------------------------------------------
	// state
	// -------------------------------------------------------------------------
	cycle_t   cycle, next_cycle;
	logic     sub, next_sub;             // subcycle, request then wait
	addr_t    pc, next_pc;
	word_t    instr, next_instr;
	addr_t    mem_addr, next_mem_addr;
	logic     req, next_req;
	logic     write, next_write;
	word_t    wdata, next_wdata;
	word_t    regs [NUM_REGS];
	word_t    next_regs [NUM_REGS];
	reg_idx_t ridx_a, next_ridx_a;       // source, or the one-address reg
	reg_idx_t ridx_b, next_ridx_b;       // transfer target
	word_t    immval, next_immval;       // word after the opcode

	// opcode fields of the current instr
	logic       two_addr;
	logic       has_imm;
	logic       valid_op;
	logic [2:0] xfer_field;
	logic [3:0] one_field;

	assign two_addr   = instr[WORD_BITS - 1];
	assign has_imm    = !two_addr && instr[WORD_BITS - 2];
	assign xfer_field = instr[WORD_BITS - 2 -: 3];
	assign one_field  = instr[WORD_BITS - 3 -: 4];
	assign valid_op   = two_addr ? (xfer_field == op_xfer)
		: has_imm && (one_field inside {op_mov_imm, op_load, op_store});

	assign bus.req   = req;
	assign bus.write = write;
	assign bus.addr  = mem_addr;
	assign bus.wdata = wdata;
	assign out_instr = instr;

	always_ff @(posedge in_clk) begin
		if (in_rst || core_hold) begin
			cycle    <= FETCH;
			sub      <= 1'b0;
			pc       <= '0;
			instr    <= '0;
			mem_addr <= '0;
			req      <= 1'b0;
			write    <= 1'b0;
			wdata    <= '0;
			regs     <= '{default: '0};
			ridx_a   <= '0;
			ridx_b   <= '0;
			immval   <= '0;
		end else begin
			cycle    <= next_cycle;
			sub      <= next_sub;
			pc       <= next_pc;
			instr    <= next_instr;
			mem_addr <= next_mem_addr;
			req      <= next_req;
			write    <= next_write;
			wdata    <= next_wdata;
			regs     <= next_regs;
			ridx_a   <= next_ridx_a;
			ridx_b   <= next_ridx_b;
			immval   <= next_immval;
		end
	end

	// -------------------------------------------------------------------------
	// instruction cycle
	// -------------------------------------------------------------------------
	always_comb begin
		next_cycle    = cycle;
		next_sub      = sub;
		next_pc       = pc;
		next_instr    = instr;
		next_mem_addr = mem_addr;
		next_req      = 1'b0;   // req is a pulse unless a write holds it
		next_write    = 1'b0;
		next_wdata    = wdata;
		next_regs     = regs;
		next_ridx_a   = ridx_a;
		next_ridx_b   = ridx_b;
		next_immval   = immval;

		case (cycle)
			FETCH, LOAD_IMM: begin // both read the word at pc
				if (!sub) begin
					next_mem_addr = pc;
					next_pc       = pc + 1'b1;
					next_req      = 1'b1;
					next_sub      = 1'b1;
				end else if (bus.ack) begin
					next_sub = 1'b0;
					if (cycle == FETCH) begin
						next_instr = bus.rdata;
						next_cycle = DECODE;
					end else begin
						next_immval = bus.rdata;
						next_cycle  = EXEC;
						if (one_field == op_store) begin // write out on entry to exec
							next_mem_addr = bus.rdata;
							next_wdata    = regs[ridx_a];
							next_req      = 1'b1;
							next_write    = 1'b1;
						end
					end
				end
			end

			DECODE: begin
				next_ridx_a = two_addr ? instr[WORD_BITS / 2 - 1 -: REG_BITS]
					: instr[0 +: REG_BITS];
				next_ridx_b = instr[0 +: REG_BITS];
				if (!valid_op)
					next_cycle = FETCH;      // skip unknown opcode
				else if (has_imm)
					next_cycle = LOAD_IMM;
				else
					next_cycle = EXEC;
			end

			EXEC: begin
				if (two_addr) begin
					next_regs[ridx_b] = regs[ridx_a]; // register transfer
					next_cycle        = FETCH;
				end else begin
					case (one_field)
						op_mov_imm: begin
							next_regs[ridx_a] = immval;
							next_cycle        = FETCH;
						end
						op_load: begin
							if (!sub) begin    // read mem[immval]
								next_mem_addr = immval;
								next_req      = 1'b1;
								next_sub      = 1'b1;
							end else if (bus.ack) begin
								next_regs[ridx_a] = bus.rdata;
								next_sub          = 1'b0;
								next_cycle        = FETCH;
							end
						end
						op_store: begin
							if (bus.ack) begin
								next_cycle = FETCH; // req and write drop here
							end else begin
								next_mem_addr = immval;
								next_wdata    = regs[ridx_a];
								next_req      = 1'b1;
								next_write    = 1'b1;
							end
						end
						default: next_cycle = FETCH;
					endcase
				end
			end

			default: next_cycle = FETCH;
		endcase
	end

	// decode is the bus idle slot between fetch and execute
	a_no_req_in_decode: assert property (@(posedge in_clk) disable iff (in_rst || core_hold)
		cycle == DECODE |-> !bus.req)
		else $error("bus request during decode");

	a_write_has_req: assert property (@(posedge in_clk) disable iff (in_rst || core_hold)
		bus.write |-> bus.req)
		else $error("write level without request");

endmodule

`default_nettype wire

// File: cpu_pkg.sv
// -------------------------------------------------------------------------
// shared types for the small register machine
// word, address and register index types, opcode fields, core cycle enum
// -------------------------------------------------------------------------
`default_nettype none

package cpu_pkg;

	typedef logic [7:0] word_t;    // data or instruction word
	typedef logic [7:0] addr_t;    // memory address
	typedef logic [1:0] reg_idx_t; // one of four registers

	// core cycle, one step of the instruction cycle each
	typedef enum logic [1:0] {
		FETCH,
		DECODE,
		LOAD_IMM,
		EXEC
	} cycle_t;

	// -------------------------------------------------------------------------
	// instruction encodings
	//   1000_aa_bb      copy register aa to register bb
	//   010000_aa val   load immediate val into aa
	//   010001_aa addr  load mem[addr] into aa
	//   010010_aa addr  store aa to mem[addr]
	// -------------------------------------------------------------------------
	localparam logic [3:0] op_mov_imm = 4'b0000; // bits 5:2 of one-address op
	localparam logic [3:0] op_load    = 4'b0001;
	localparam logic [3:0] op_store   = 4'b0010;
	localparam logic [2:0] op_xfer    = 3'b000;  // bits 6:4 of two-address op

	localparam addr_t out_port_addr = 8'hff; // memory mapped output register

endpackage

`default_nettype wire

// File: cpu_system.sv
// -------------------------------------------------------------------------
// system top
// program loader, cpu core and memory map joined by two bus instances
// -------------------------------------------------------------------------
`default_nettype none

module cpu_system #(
	parameter int ADDR_BITS = 8,
	parameter int WORD_BITS = 8,
	parameter int RAM_DEPTH = 255
) (
	input wire in_clk,
	input wire in_rst,
	input wire in_run,                       // low holds the core, allows loading
	input wire in_load_strobe,
	input wire cpu_pkg::addr_t in_load_addr,
	input wire cpu_pkg::word_t in_load_data,
	output cpu_pkg::word_t out_port,
	output logic out_port_strobe,
	output cpu_pkg::word_t out_instr         // debug
);

	mem_bus_if core_bus (); // core to loader
	mem_bus_if sys_bus ();  // loader to memory map

	logic core_hold;

	prog_loader u_loader (
		.in_clk(in_clk),
		.in_rst(in_rst),
		.in_run(in_run),
		.in_load_strobe(in_load_strobe),
		.in_load_addr(in_load_addr),
		.in_load_data(in_load_data),
		.core(core_bus),
		.mem(sys_bus),
		.core_hold(core_hold)
	);

	cpu_core #(
		.ADDR_BITS(ADDR_BITS),
		.WORD_BITS(WORD_BITS)
	) u_core (
		.in_clk(in_clk),
		.in_rst(in_rst),
		.core_hold(core_hold),
		.bus(core_bus),
		.out_instr(out_instr)
	);

	mem_map #(
		.RAM_DEPTH(RAM_DEPTH)
	) u_mem_map (
		.in_clk(in_clk),
		.in_rst(in_rst),
		.bus(sys_bus),
		.out_port(out_port),
		.out_port_strobe(out_port_strobe)
	);

endmodule

`default_nettype wire

// File: filelist.f
cpu_pkg.sv
mem_bus_if.sv
prog_loader.sv
cpu_core.sv
mem_ram.sv
mem_map.sv
cpu_system.sv
tb_checker.sv
tb_cpu_system.sv

// File: mem_bus_if.sv
// -------------------------------------------------------------------------
// memory bus between one master and one slave
// read is a one cycle req pulse, write holds req and write until ack
// -------------------------------------------------------------------------
`default_nettype none

interface mem_bus_if ();
	import cpu_pkg::*;

	logic  req;   // request strobe
	logic  write; // write level, valid with req
	addr_t addr;
	word_t wdata;
	word_t rdata; // valid with ack
	logic  ack;   // one cycle pulse

	// requester side
	modport master (
		output req, write, addr, wdata,
		input  rdata, ack
	);

	// responder side
	modport slave (
		input  req, write, addr, wdata,
		output rdata, ack
	);

endinterface

`default_nettype wire

// File: mem_map.sv
// -------------------------------------------------------------------------
// memory map
// ram below the output register, output register at the top address,
// one ack per request, output strobe on each port write
// -------------------------------------------------------------------------
`default_nettype none

module mem_map #(
	parameter int RAM_DEPTH = 255
) (
	input wire in_clk,
	input wire in_rst,
	mem_bus_if.slave bus,
	output cpu_pkg::word_t out_port,
	output logic out_port_strobe
);
	import cpu_pkg::*;

	mem_bus_if ram_bus ();

	logic  accept;     // new request, not the tail of a held write
	logic  ram_hit;
	logic  port_hit;
	logic  ram_sel;
	logic  port_wr;
	logic  port_ack;   // ack for port and unmapped addresses
	word_t port_rdata;

	// a held write is still high in its ack cycle, skip it there
	assign accept   = bus.req && !bus.ack;
	assign ram_hit  = bus.addr < RAM_DEPTH;
	assign port_hit = bus.addr == out_port_addr;
	assign ram_sel  = accept && ram_hit;
	assign port_wr  = accept && port_hit && bus.write;

	assign ram_bus.req   = bus.req;
	assign ram_bus.write = bus.write;
	assign ram_bus.addr  = bus.addr;
	assign ram_bus.wdata = bus.wdata;

	mem_ram #(
		.RAM_DEPTH(RAM_DEPTH)
	) u_ram (
		.in_clk(in_clk),
		.in_rst(in_rst),
		.sel(ram_sel),
		.bus(ram_bus)
	);

	// -------------------------------------------------------------------------
	// output register
	// -------------------------------------------------------------------------
	always_ff @(posedge in_clk) begin
		if (in_rst) begin
			port_ack        <= 1'b0;
			out_port        <= '0;
			out_port_strobe <= 1'b0;
		end else begin
			port_ack        <= accept && !ram_hit;
			out_port_strobe <= port_wr;   // same cycle as the ack
			if (port_wr)
				out_port <= bus.wdata;
		end
	end

	// read back of the port, zero for holes in the map
	always_ff @(posedge in_clk) begin
		if (accept && !ram_hit)
			port_rdata <= port_hit ? out_port : '0;
	end

	assign bus.ack   = ram_bus.ack || port_ack;
	assign bus.rdata = port_ack ? port_rdata : ram_bus.rdata;

endmodule

`default_nettype wire

// File: mem_ram.sv
// -------------------------------------------------------------------------
// single port synchronous ram
// ack and read data one cycle after a selected request
// -------------------------------------------------------------------------
`default_nettype none

module mem_ram #(
	parameter int RAM_DEPTH = 255
) (
	input wire in_clk,
	input wire in_rst,
	input wire sel,       // address decoded to ram, from mem_map
	mem_bus_if.slave bus
);
	import cpu_pkg::*;

	word_t mem [RAM_DEPTH];
	word_t rdata_q;
	logic  ack_q;
	logic  hit;

	assign hit = bus.req && sel;

	always_ff @(posedge in_clk) begin
		if (in_rst)
			ack_q <= 1'b0;
		else
			ack_q <= hit;    // one cycle latency
	end

	always_ff @(posedge in_clk) begin
		if (hit) begin
			if (bus.write)
				mem[bus.addr] <= bus.wdata;
			rdata_q <= mem[bus.addr]; // old word on a write, ignored
		end
	end

	assign bus.ack   = ack_q;
	assign bus.rdata = rdata_q;

	// decode in mem_map keeps the ram inside its range
	a_sel_in_range: assert property (@(posedge in_clk) disable iff (in_rst)
		hit |-> bus.addr < RAM_DEPTH)
		else $error("ram selected out of range");

endmodule

`default_nettype wire

// File: prog_loader.sv
// -------------------------------------------------------------------------
// program loader
// writes outside program words to memory while run is low,
// passes the core bus through to memory once run is high
// -------------------------------------------------------------------------
`default_nettype none

module prog_loader (
	input wire in_clk,
	input wire in_rst,
	input wire in_run,                       // low while loading
	input wire in_load_strobe,
	input wire cpu_pkg::addr_t in_load_addr,
	input wire cpu_pkg::word_t in_load_data,
	mem_bus_if.slave core,                   // from cpu core
	mem_bus_if.master mem,                   // to memory map
	output logic core_hold                   // keeps core in reset
);
	import cpu_pkg::*;

	logic  load_req;  // pending write of one program word
	addr_t load_addr;
	word_t load_data;

	// request goes out the cycle after the strobe, dropped on ack
	always_ff @(posedge in_clk) begin
		if (in_rst) begin
			load_req <= 1'b0;
		end else if (in_run) begin
			load_req <= 1'b0;        // nothing left over once running
		end else if (in_load_strobe) begin
			load_req <= 1'b1;
		end else if (mem.ack) begin
			load_req <= 1'b0;
		end
	end

	always_ff @(posedge in_clk) begin
		if (!in_run && in_load_strobe) begin
			load_addr <= in_load_addr;
			load_data <= in_load_data;
		end
	end

	// bus mux, loader owns memory while run is low
	assign mem.req   = in_run ? core.req : load_req;
	assign mem.write = in_run ? core.write : load_req; // loader only writes
	assign mem.addr  = in_run ? core.addr : load_addr;
	assign mem.wdata = in_run ? core.wdata : load_data;

	assign core.ack   = in_run && mem.ack; // no stray ack into a held core
	assign core.rdata = mem.rdata;
	assign core_hold  = !in_run;

	// program words only come in before the run starts
	a_no_load_while_run: assert property (@(posedge in_clk) disable iff (in_rst)
		in_load_strobe |-> !in_run)
		else $error("load strobe while running");

endmodule

`default_nettype wire

// File: tb_checker.sv
// -------------------------------------------------------------------------
// output checker for the cpu system testbench
// compares each output strobe with the expected words of the running test,
// prints one line per finished test and the closing counts
// -------------------------------------------------------------------------
`default_nettype none

module tb_checker (
	input wire in_clk,
	input wire in_rst,
	input wire [7:0] port_data,  // dut out_port
	input wire port_strobe,      // dut out_port_strobe
	input wire [7:0] instr_data  // dut out_instr
);
	string      test_name;
	logic [7:0] expected [$];   // words still to come, in order
	logic [7:0] expected_instr [$]; // store op behind each word
	int         seen;
	int         test_errors;
	bit         active;
	int         pass_count;
	int         fail_count;
	int         stray_count;    // strobes with no test running
	event       test_done;

	initial begin
		active      = 1'b0;
		pass_count  = 0;
		fail_count  = 0;
		stray_count = 0;
	end

	task automatic push_expected(input logic [7:0] word, input logic [7:0] instr);
		expected.push_back(word);
		expected_instr.push_back(instr);
	endtask

	task automatic start_test(input string name);
		test_name   = name;
		seen        = 0;
		test_errors = 0;
		active      = 1'b1;
	endtask

	// port and strobe change on the rising edge, so look at the falling one
	always @(negedge in_clk) begin
		logic [7:0] want;
		logic [7:0] want_instr;
		if (!in_rst && port_strobe) begin
			if (!active || expected.size() == 0) begin
				stray_count++;
				$display("unexpected output strobe with value %02h while no test runs",
					port_data);
			end else begin
				want       = expected.pop_front();
				want_instr = expected_instr.pop_front();
				seen++;
				if (port_data !== want) begin
					test_errors++;
					$display("Fail %s: expected %02h, actual %02h", test_name, want, port_data);
				end
				if (instr_data !== want_instr) begin // store still in instr
					test_errors++;
					$display("Fail %s: expected instr %02h, actual instr %02h",
						test_name, want_instr, instr_data);
				end
				if (expected.size() == 0) begin  // last output of this test
					if (test_errors == 0) begin
						pass_count++;
						$display("pass %s: %0d outputs", test_name, seen);
					end else begin
						fail_count++;
						$display("test %s done with %0d wrong outputs", test_name, test_errors);
					end
					active = 1'b0;
					-> test_done;
				end
			end
		end
	end

	task automatic print_counts();
		$display("%0d tests passed, %0d failed, %0d stray outputs",
			pass_count, fail_count, stray_count);
	endtask

	function automatic bit all_good(input int tests_run);
		return fail_count == 0 && stray_count == 0 && pass_count == tests_run;
	endfunction

endmodule

`default_nettype wire

// File: tb_cpu_system.sv
// -------------------------------------------------------------------------
// testbench top for the cpu system
// clock, reset, test table of programs and expected outputs,
// program loading loop and cycle timeout
// -------------------------------------------------------------------------
`default_nettype none

module tb_cpu_system;
	localparam int max_tests = 8;
	localparam int max_words = 16;

	logic       in_clk;
	logic       in_rst;
	logic       in_run;
	logic       in_load_strobe;
	logic [7:0] in_load_addr;
	logic [7:0] in_load_data;
	logic [7:0] out_port;
	logic       out_port_strobe;
	logic [7:0] out_instr;

	// -------------------------------------------------------------------------
	// test table, one row per test
	// -------------------------------------------------------------------------
	string      names [max_tests];
	logic [7:0] prog [max_tests][max_words];
	int         prog_len [max_tests];
	logic [7:0] outs [max_tests][max_words];
	logic [7:0] out_ops [max_tests][max_words]; // store op behind each output
	int         out_len [max_tests];
	int         num_tests;

	int         cycle_count;
	int         cycle_limit;  // from the table

	cpu_system DUT (
		.in_clk(in_clk),
		.in_rst(in_rst),
		.in_run(in_run),
		.in_load_strobe(in_load_strobe),
		.in_load_addr(in_load_addr),
		.in_load_data(in_load_data),
		.out_port(out_port),
		.out_port_strobe(out_port_strobe),
		.out_instr(out_instr)
	);

	tb_checker u_checker (
		.in_clk(in_clk),
		.in_rst(in_rst),
		.port_data(out_port),
		.port_strobe(out_port_strobe),
		.instr_data(out_instr)
	);

	initial in_clk = 1'b0;
	always #50 in_clk = ~in_clk;

	task automatic new_test(input string name);
		names[num_tests]    = name;
		prog_len[num_tests] = 0;
		out_len[num_tests]  = 0;
		num_tests++;
	endtask

	task automatic add_word(input logic [7:0] w);
		prog[num_tests - 1][prog_len[num_tests - 1]] = w;
		prog_len[num_tests - 1]++;
	endtask

	task automatic add_pair(input logic [7:0] op, input logic [7:0] arg);
		add_word(op);
		add_word(arg);  // immediate value or address
	endtask

	task automatic add_out(input logic [7:0] w, input logic [7:0] op);
		outs[num_tests - 1][out_len[num_tests - 1]]    = w;
		out_ops[num_tests - 1][out_len[num_tests - 1]] = op;
		out_len[num_tests - 1]++;
	endtask

	// 40+r ldi, 44+r ld, 48+r st, 80+aa*4+bb copy aa to bb
	task automatic build_table();
		num_tests = 0;
		new_test("imm_store");
		add_pair(8'h40, 8'h5a);   // r0 = 5a
		add_pair(8'h48, 8'hff);   // port = r0
		add_out(8'h5a, 8'h48);
		new_test("reg_xfer");
		add_pair(8'h40, 8'hc3);
		add_word(8'h83);          // r3 = r0
		add_pair(8'h4b, 8'hff);
		add_out(8'hc3, 8'h4b);
		new_test("ram_round_trip");
		add_pair(8'h41, 8'ha7);
		add_pair(8'h49, 8'h80);   // mem[80] = r1
		add_pair(8'h46, 8'h80);   // r2 = mem[80]
		add_pair(8'h4a, 8'hff);
		add_out(8'ha7, 8'h4a);
		new_test("data_word");
		add_pair(8'h44, 8'h04);   // r0 = word at 04
		add_pair(8'h48, 8'hff);
		add_word(8'h3c);          // data in the image
		add_out(8'h3c, 8'h48);
		new_test("multi_store");
		add_pair(8'h40, 8'h11);
		add_pair(8'h41, 8'h22);
		add_pair(8'h42, 8'h33);
		add_pair(8'h48, 8'hff);
		add_pair(8'h49, 8'hff);
		add_pair(8'h4a, 8'hff);
		add_out(8'h11, 8'h48);
		add_out(8'h22, 8'h49);
		add_out(8'h33, 8'h4a);
		new_test("bad_opcode");
		add_pair(8'h40, 8'h66);
		add_pair(8'h48, 8'hff);
		add_word(8'h4c);          // undefined one-address op
		add_pair(8'h41, 8'h99);
		add_pair(8'h49, 8'hff);
		add_out(8'h66, 8'h48);
		add_out(8'h99, 8'h49);
	endtask

	// one strobe every fourth cycle, last write done on return
	task automatic load_program(input int t);
		for (int i = 0; i < prog_len[t]; i++) begin
			@(posedge in_clk);
			in_load_strobe <= 1'b1;
			in_load_addr   <= i[7:0];
			in_load_data   <= prog[t][i];
			@(posedge in_clk);
			in_load_strobe <= 1'b0;
			repeat (2) @(posedge in_clk);
		end
	endtask

	initial begin
		in_rst         = 1'b1;
		in_run         = 1'b0;
		in_load_strobe = 1'b0;
		in_load_addr   = '0;
		in_load_data   = '0;
		cycle_count    = 0;
		build_table();
		cycle_limit = 0;
		for (int t = 0; t < num_tests; t++)
			cycle_limit += 12 * prog_len[t] + 20;
		repeat (2) @(posedge in_clk);
		in_rst <= 1'b0;

		for (int t = 0; t < num_tests; t++) begin
			@(posedge in_clk);
			in_run <= 1'b0;              // core held, loader owns memory
			load_program(t);
			@(posedge in_clk);
			in_run <= 1'b1;
			for (int k = 0; k < out_len[t]; k++)
				u_checker.push_expected(outs[t][k], out_ops[t][k]);
			u_checker.start_test(names[t]);
			@(u_checker.test_done);
		end

		@(posedge in_clk);
		in_run <= 1'b0;
		u_checker.print_counts();
		if (u_checker.all_good(num_tests))
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

	// run limit, a stuck core never reaches its last output
	always @(posedge in_clk) begin
		cycle_count++;
		if (cycle_count >= cycle_limit) begin
			$display("timeout after %0d cycles, a test did not finish", cycle_count);
			$display("Testbench failed");
			$finish;
		end
	end

endmodule

`default_nettype wire
